/* voxel_mem_shell.f */
+incdir+source
source/shell_dma_pkg.sv
source/shell_bus_pkg.sv
source/shell_csr.sv
source/copy_dma.sv
source/mem_arbiter.sv
source/word_memory.sv
source/voxel_mem_shell.sv
test/voxel_mem_shell_props.sv
test/voxel_mem_shell_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory shell testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module voxel_mem_shell_tb -f voxel_mem_shell.f \
        -o voxel_mem_shell_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/voxel_mem_shell_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Result: failure"
    exit 1
fi

echo "Result: success"
exit 0

/* test/voxel_mem_shell_tb.sv */
// --------------------
// Memory shell testbench with clock, reset, AXI-Lite
// and memory port tasks and copy tests against a model
// --------------------
`default_nettype none

`include "shell_config.svh"

module voxel_mem_shell_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NUM_TESTS      = 6;

    logic                     clk = 1'b0;
    logic                     rst_n = 1'b0;
    shell_bus_pkg::axil_req_t axil_req;
    shell_bus_pkg::axil_rsp_t axil_rsp;
    shell_bus_pkg::mem_req_t  ext_req;
    logic                     ext_ready;
    shell_dma_pkg::mem_word_t ext_rdata;
    logic                     ext_rvalid;
    logic                     irq;
    logic                     msi;

    // Reference model of the memory and of SRC, DST, LEN and IRQ_EN
    shell_dma_pkg::mem_word_t model_mem [`SHELL_MEM_DEPTH];
    logic [31:0]              reg_model [4];

    int errors = 0;
    int start_errors = 0;
    int cycles = 0;
    int msi_count = 0;

    voxel_mem_shell u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .ext_req    (ext_req),
        .ext_ready  (ext_ready),
        .ext_rdata  (ext_rdata),
        .ext_rvalid (ext_rvalid),
        .irq        (irq),
        .msi        (msi)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst_n && msi) begin
            msi_count++;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - start_errors);
        start_errors = errors;
    endtask

    function automatic logic [15:0] reg_offset(input int sel);
        case (sel)
            0:       return `SHELL_REG_SRC;
            1:       return `SHELL_REG_DST;
            2:       return `SHELL_REG_LEN;
            default: return `SHELL_REG_IRQ_EN;
        endcase
    endfunction

    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        logic taken;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        do begin
            @(negedge clk);
            taken = axil_rsp.awready;
            @(posedge clk);
            #1;
        end while (!taken);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        do begin
            @(negedge clk);
            taken = axil_rsp.bvalid;
            resp  = axil_rsp.bresp;
            @(posedge clk);
            #1;
        end while (!taken);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic taken;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        do begin
            @(negedge clk);
            taken = axil_rsp.arready;
            @(posedge clk);
            #1;
        end while (!taken);
        axil_req.arvalid = 1'b0;
        do begin
            @(negedge clk);
            taken = axil_rsp.rvalid;
            data  = axil_rsp.rdata;
            resp  = axil_rsp.rresp;
            @(posedge clk);
            #1;
        end while (!taken);
        axil_req.rready = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, 4'hF, resp);
        if (resp !== `SHELL_RESP_OKAY) report_mismatch("bresp", 64'h0, 64'(resp));
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [31:0] expected,
                              input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        if (resp !== `SHELL_RESP_OKAY) report_mismatch("rresp", 64'h0, 64'(resp));
        if (data !== expected) report_mismatch(name, 64'(expected), 64'(data));
    endtask

    task automatic ext_write(input shell_dma_pkg::word_addr_t addr,
                             input shell_dma_pkg::mem_word_t data);
        logic taken;
        ext_req.en    = 1'b1;
        ext_req.we    = 1'b1;
        ext_req.addr  = addr;
        ext_req.wdata = data;
        do begin
            @(negedge clk);
            taken = ext_ready;
            @(posedge clk);
            #1;
        end while (!taken);
        ext_req = '0;
        model_mem[addr] = data;
    endtask

    // Valid must be low before the request edge and high right after it
    task automatic ext_read(input shell_dma_pkg::word_addr_t addr,
                            output shell_dma_pkg::mem_word_t data);
        logic taken;
        logic early;
        ext_req.en   = 1'b1;
        ext_req.we   = 1'b0;
        ext_req.addr = addr;
        do begin
            @(negedge clk);
            taken = ext_ready;
            early = ext_rvalid;
            @(posedge clk);
            #1;
        end while (!taken);
        ext_req = '0;
        if (early !== 1'b0) report_mismatch("ext_rvalid early", 64'h0, 64'(early));
        @(negedge clk);
        if (ext_rvalid !== 1'b1) report_mismatch("ext_rvalid", 64'h1, 64'(ext_rvalid));
        data = ext_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic start_copy(input int src, input int dst, input int len);
        write_reg(`SHELL_REG_SRC, 32'(src));
        write_reg(`SHELL_REG_DST, 32'(dst));
        write_reg(`SHELL_REG_LEN, 32'(len));
        write_reg(`SHELL_REG_CTRL, 32'h1);
        for (int i = 0; i < len; i++) begin
            model_mem[dst + i] = model_mem[src + i];
        end
    endtask

    task automatic wait_copy_done();
        logic [31:0] data;
        logic [1:0]  resp;
        do begin
            axil_read(`SHELL_REG_IRQ_STAT, data, resp);
        end while (data[0] !== 1'b1);
    endtask

    task automatic verify_range(input int base, input int len);
        shell_dma_pkg::mem_word_t data;
        for (int i = 0; i < len; i++) begin
            ext_read(10'(base + i), data);
            if (data !== model_mem[base + i]) begin
                report_mismatch("ext_rdata", model_mem[base + i], data);
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int                       sel;
        int                       src;
        int                       dst;
        int                       len;
        int                       written [$];
        logic [31:0]              data;
        logic [31:0]              mask;
        logic [3:0]               strb;
        logic [1:0]               resp;
        logic                     seen;
        shell_dma_pkg::word_addr_t addr;
        shell_dma_pkg::mem_word_t word;

        void'($urandom(32'h440c));
        axil_req = '0;
        ext_req  = '0;
        for (int i = 0; i < 4; i++) begin
            reg_model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Test 1 covers reset values, the ID and an unknown offset
        @(negedge clk);
        if ({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid, axil_rsp.arready,
             axil_rsp.rvalid, irq, msi, ext_rvalid, ext_ready} !== 9'h001) begin
            report_mismatch("reset outputs", 64'h001, 64'({axil_rsp.awready,
                axil_rsp.wready, axil_rsp.bvalid, axil_rsp.arready, axil_rsp.rvalid,
                irq, msi, ext_rvalid, ext_ready}));
        end
        @(posedge clk);
        #1;
        read_check(`SHELL_REG_ID, `SHELL_ID_VALUE, "rdata id");
        read_check(`SHELL_REG_STATUS, 32'h0, "rdata status");
        axil_read(16'h0040, data, resp);
        if (resp !== `SHELL_RESP_SLVERR) report_mismatch("rresp unknown", 64'h2, 64'(resp));
        if (data !== 32'h0) report_mismatch("rdata unknown", 64'h0, 64'(data));
        axil_write(16'h0040, 32'hFFFF_FFFF, 4'hF, resp);
        if (resp !== `SHELL_RESP_SLVERR) report_mismatch("bresp unknown", 64'h2, 64'(resp));
        end_test(1, "reset and ID");

        // Test 2 covers byte-strobed register writes
        for (int n = 0; n < 32; n++) begin
            sel  = $urandom_range(3, 0);
            data = $urandom;
            strb = 4'($urandom);
            mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            axil_write(reg_offset(sel), data, strb, resp);
            if (resp !== `SHELL_RESP_OKAY) report_mismatch("bresp", 64'h0, 64'(resp));
            if (sel < 3) begin
                reg_model[sel] = (reg_model[sel] & ~mask) | (data & mask);
            end else if (strb[0]) begin
                reg_model[3] = {31'b0, data[0]};
            end
            read_check(reg_offset(sel), reg_model[sel], "rdata register");
        end
        write_reg(`SHELL_REG_STATUS, $urandom);
        write_reg(`SHELL_REG_ID, $urandom);
        read_check(`SHELL_REG_STATUS, 32'h0, "rdata status");
        read_check(`SHELL_REG_ID, `SHELL_ID_VALUE, "rdata id");
        write_reg(`SHELL_REG_IRQ_EN, 32'h0);
        end_test(2, "register access");

        // Test 3 fills the copy window and then checks random external accesses
        for (int i = 0; i < 256; i++) begin
            ext_write(10'(i), {$urandom, $urandom});
            written.push_back(i);
        end
        for (int n = 0; n < 64; n++) begin
            addr = 10'($urandom);
            ext_write(addr, {$urandom, $urandom});
            written.push_back(int'(addr));
        end
        for (int n = 0; n < 64; n++) begin
            addr = 10'(written[$urandom_range(written.size() - 1, 0)]);
            ext_read(addr, word);
            if (word !== model_mem[addr]) report_mismatch("ext_rdata", model_mem[addr], word);
        end
        end_test(3, "external memory");

        // Test 4 runs random copies from below 128 to above 128
        for (int n = 0; n < 10; n++) begin
            src = $urandom_range(100, 0);
            dst = $urandom_range(239, 128);
            len = $urandom_range(16, 0);
            start_copy(src, dst, len);
            wait_copy_done();
            write_reg(`SHELL_REG_IRQ_STAT, 32'h1);
            verify_range(dst, len);
        end
        end_test(4, "random copies");

        // Test 5 checks the port gate and an ignored restart while busy
        src = $urandom_range(100, 0);
        dst = $urandom_range(239, 128);
        start_copy(src, dst, 8);
        read_check(`SHELL_REG_STATUS, 32'h1, "rdata status busy");
        write_reg(`SHELL_REG_SRC, 32'(src + 1));
        write_reg(`SHELL_REG_CTRL, 32'h1);
        repeat (10) begin
            @(negedge clk);
            if (ext_ready !== 1'b0) report_mismatch("ext_ready", 64'h0, 64'(ext_ready));
            @(posedge clk);
            #1;
        end
        wait_copy_done();
        read_check(`SHELL_REG_STATUS, 32'h0, "rdata status idle");
        write_reg(`SHELL_REG_IRQ_STAT, 32'h1);
        verify_range(dst, 8);
        end_test(5, "busy gating");

        // Test 6 checks irq and msi with IRQ_EN set and then clear
        write_reg(`SHELL_REG_IRQ_EN, 32'h1);
        msi_count = 0;
        len = $urandom_range(16, 1);
        start_copy(src, dst, len);
        do begin
            @(negedge clk);
            seen = irq;
            @(posedge clk);
            #1;
        end while (!seen);
        repeat (3) @(posedge clk);
        #1;
        if (msi_count != 1) report_mismatch("msi pulses", 64'h1, 64'(msi_count));
        read_check(`SHELL_REG_IRQ_STAT, 32'h1, "rdata irq_stat");
        write_reg(`SHELL_REG_IRQ_STAT, 32'h1);
        @(negedge clk);
        if (irq !== 1'b0) report_mismatch("irq after clear", 64'h0, 64'(irq));
        @(posedge clk);
        #1;
        verify_range(dst, len);
        write_reg(`SHELL_REG_IRQ_EN, 32'h0);
        msi_count = 0;
        start_copy(src, dst, len);
        wait_copy_done();
        @(negedge clk);
        if (irq !== 1'b0) report_mismatch("irq masked", 64'h0, 64'(irq));
        if (msi_count != 0) report_mismatch("msi masked", 64'h0, 64'(msi_count));
        @(posedge clk);
        #1;
        write_reg(`SHELL_REG_IRQ_STAT, 32'h1);
        end_test(6, "interrupt");

        $display("%0d tests run, %0d checks failed", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/voxel_mem_shell_props.sv */
// --------------------
// Bound checks on the AXI-Lite response holds,
// the external port gate and the MSI pulse
// --------------------
`default_nettype none

module voxel_mem_shell_props (
    input logic                     clk,
    input logic                     rst_n,
    input shell_bus_pkg::axil_req_t axil_req,
    input shell_bus_pkg::axil_rsp_t axil_rsp,
    input logic                     dma_busy,
    input logic                     ext_rvalid,
    input logic                     irq,
    input logic                     msi
);
    timeunit 1ns;
    timeprecision 1ps;

    // Write response stays up with a stable code until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else $error("bvalid dropped or bresp changed before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid dropped or rdata changed before rready");

    // Copy engine owns the memory while busy
    ext_gate: assert property (@(posedge clk) disable iff (!rst_n)
        dma_busy |=> !ext_rvalid)
        else $error("external read served while the copy engine was busy");

    msi_single: assert property (@(posedge clk) disable iff (!rst_n)
        msi |=> !msi)
        else $error("msi high for more than one cycle");

    msi_after_rise: assert property (@(posedge clk) disable iff (!rst_n)
        msi |-> irq && !$past(irq))
        else $error("msi without a rising irq");

endmodule

bind voxel_mem_shell voxel_mem_shell_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .dma_busy   (dma_busy),
    .ext_rvalid (ext_rvalid),
    .irq        (irq),
    .msi        (msi)
);

`default_nettype wire

/* source/voxel_mem_shell.sv */
// ------------------
// Shell top: register block, copy engine,
// arbiter and word memory
// ------------------
`default_nettype none

module voxel_mem_shell (
    input  logic                     clk,
    input  logic                     rst_n,
    input  shell_bus_pkg::axil_req_t axil_req,
    output shell_bus_pkg::axil_rsp_t axil_rsp,
    input  shell_bus_pkg::mem_req_t  ext_req,
    output logic                     ext_ready,
    output shell_dma_pkg::mem_word_t ext_rdata,
    output logic                     ext_rvalid,
    output logic                     irq,
    output logic                     msi
);

    logic                       dma_start;
    logic                       dma_busy;
    logic                       dma_done;
    logic                       dma_rvalid;
    logic                       mem_rvalid;
    shell_dma_pkg::word_addr_t  dma_src;
    shell_dma_pkg::word_addr_t  dma_dst;
    shell_dma_pkg::word_count_t dma_len;
    shell_dma_pkg::mem_word_t   mem_rdata;
    shell_bus_pkg::mem_req_t    dma_req;
    shell_bus_pkg::mem_req_t    mem_req;

    shell_csr u_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .dma_busy  (dma_busy),
        .dma_done  (dma_done),
        .dma_start (dma_start),
        .dma_src   (dma_src),
        .dma_dst   (dma_dst),
        .dma_len   (dma_len),
        .irq       (irq),
        .msi       (msi)
    );

    // Read data is shared, so the engine listens on ext_rdata
    copy_dma u_dma (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (dma_start),
        .src        (dma_src),
        .dst        (dma_dst),
        .len        (dma_len),
        .busy       (dma_busy),
        .done       (dma_done),
        .mem_req    (dma_req),
        .mem_rdata  (ext_rdata),
        .mem_rvalid (dma_rvalid)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .dma_busy   (dma_busy),
        .dma_req    (dma_req),
        .ext_req    (ext_req),
        .ext_ready  (ext_ready),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid),
        .dma_rvalid (dma_rvalid),
        .ext_rvalid (ext_rvalid),
        .rdata      (ext_rdata)
    );

    word_memory u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (mem_req),
        .rdata  (mem_rdata),
        .rvalid (mem_rvalid)
    );

endmodule

`default_nettype wire

/* source/word_memory.sv */
// ------------------
// Single-port word RAM
// one-cycle read latency, read-valid strobe
// ------------------
`default_nettype none

`include "shell_config.svh"

module word_memory (
    input  logic                     clk,
    input  logic                     rst_n,
    input  shell_bus_pkg::mem_req_t  req,
    output shell_dma_pkg::mem_word_t rdata,
    output logic                     rvalid
);

    shell_dma_pkg::mem_word_t mem_q [`SHELL_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we) begin
                mem_q[req.addr] <= req.wdata;
            end else begin
                rdata <= mem_q[req.addr];
            end
        end
    end

    // Valid follows each read by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= req.en & ~req.we;
        end
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
// ------------------
// Memory port arbiter, copy engine owns the
// memory while busy, read valid steered to owner
// ------------------
`default_nettype none

module mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dma_busy,
    input  shell_bus_pkg::mem_req_t  dma_req,
    input  shell_bus_pkg::mem_req_t  ext_req,
    output logic                     ext_ready,
    output shell_bus_pkg::mem_req_t  mem_req,
    input  shell_dma_pkg::mem_word_t mem_rdata,
    input  logic                     mem_rvalid,
    output logic                     dma_rvalid,
    output logic                     ext_rvalid,
    output shell_dma_pkg::mem_word_t rdata
);

    // Set when the read in flight came from the copy engine
    logic owner_dma_q;

    assign ext_ready = ~dma_busy;

    // External requests without ready are simply dropped
    always_comb begin
        if (dma_busy) begin
            mem_req = dma_req;
        end else begin
            mem_req = ext_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_dma_q <= 1'b0;
        end else if (mem_req.en && !mem_req.we) begin
            owner_dma_q <= dma_busy;
        end
    end

    assign dma_rvalid = mem_rvalid & owner_dma_q;
    assign ext_rvalid = mem_rvalid & ~owner_dma_q;

    // Both sides see the same data bus
    assign rdata = mem_rdata;

endmodule

`default_nettype wire

/* source/copy_dma.sv */
// ------------------
// Word-by-word copy engine
// read, wait for data, write, repeat
// ------------------
`default_nettype none

module copy_dma (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  shell_dma_pkg::word_addr_t   src,
    input  shell_dma_pkg::word_addr_t   dst,
    input  shell_dma_pkg::word_count_t  len,
    output logic                        busy,
    output logic                        done,
    output shell_bus_pkg::mem_req_t     mem_req,
    input  shell_dma_pkg::mem_word_t    mem_rdata,
    input  logic                        mem_rvalid
);

    shell_dma_pkg::dma_state_t  state_q;
    shell_dma_pkg::dma_state_t  state_d;
    shell_dma_pkg::word_addr_t  rd_addr_q;
    shell_dma_pkg::word_addr_t  wr_addr_q;
    shell_dma_pkg::word_count_t left_q;
    shell_dma_pkg::mem_word_t   data_q;

    // --------------------
    // State machine
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            shell_dma_pkg::IDLE: begin
                // Zero length goes straight to done
                if (start && len == '0) begin
                    state_d = shell_dma_pkg::FINISH;
                end else if (start) begin
                    state_d = shell_dma_pkg::READ;
                end
            end
            shell_dma_pkg::READ: state_d = shell_dma_pkg::WAIT;
            shell_dma_pkg::WAIT: begin
                if (mem_rvalid) begin
                    state_d = shell_dma_pkg::WRITE;
                end
            end
            shell_dma_pkg::WRITE: begin
                if (left_q == shell_dma_pkg::word_count_t'(1)) begin
                    state_d = shell_dma_pkg::FINISH;
                end else begin
                    state_d = shell_dma_pkg::READ;
                end
            end
            default: state_d = shell_dma_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= shell_dma_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Pointers, remaining count and the word in flight
    always_ff @(posedge clk) begin
        if (state_q == shell_dma_pkg::IDLE && start) begin
            rd_addr_q <= src;
            wr_addr_q <= dst;
            left_q    <= len;
        end
        if (state_q == shell_dma_pkg::WAIT && mem_rvalid) begin
            data_q <= mem_rdata;
        end
        if (state_q == shell_dma_pkg::WRITE) begin
            rd_addr_q <= rd_addr_q + 1'b1;
            wr_addr_q <= wr_addr_q + 1'b1;
            left_q    <= left_q - 1'b1;
        end
    end

    always_comb begin
        mem_req = '0;
        if (state_q == shell_dma_pkg::READ) begin
            mem_req.en   = 1'b1;
            mem_req.addr = rd_addr_q;
        end else if (state_q == shell_dma_pkg::WRITE) begin
            mem_req.en    = 1'b1;
            mem_req.we    = 1'b1;
            mem_req.addr  = wr_addr_q;
            mem_req.wdata = data_q;
        end
    end

    assign busy = (state_q != shell_dma_pkg::IDLE);
    assign done = (state_q == shell_dma_pkg::FINISH);

endmodule

`default_nettype wire

/* source/shell_csr.sv */
// ------------------
// AXI-Lite register slave for the copy engine:
// register file, start pulse, IRQ status, MSI pulse
// ------------------
`default_nettype none

`include "shell_config.svh"

module shell_csr (
    input  logic                        clk,
    input  logic                        rst_n,
    input  shell_bus_pkg::axil_req_t    axil_req,
    output shell_bus_pkg::axil_rsp_t    axil_rsp,
    input  logic                        dma_busy,
    input  logic                        dma_done,
    output logic                        dma_start,
    output shell_dma_pkg::word_addr_t   dma_src,
    output shell_dma_pkg::word_addr_t   dma_dst,
    output shell_dma_pkg::word_count_t  dma_len,
    output logic                        irq,
    output logic                        msi
);

    logic                      wr_acc;
    logic                      rd_acc;
    logic                      wr_known;
    logic                      rd_known;
    logic                      wr_ctrl;
    logic                      wr_src;
    logic                      wr_dst;
    logic                      wr_len;
    logic                      wr_irq_en;
    logic                      wr_irq_stat;
    shell_bus_pkg::axil_data_t rd_word;

    logic                      bvalid_q;
    logic                      rvalid_q;
    shell_bus_pkg::axil_resp_t bresp_q;
    shell_bus_pkg::axil_resp_t rresp_q;
    shell_bus_pkg::axil_data_t rdata_q;

    shell_bus_pkg::axil_data_t src_q;
    shell_bus_pkg::axil_data_t dst_q;
    shell_bus_pkg::axil_data_t len_q;
    logic                      irq_en_q;
    logic                      irq_stat_q;
    logic                      irq_q;

    function automatic shell_bus_pkg::axil_data_t merge_bytes(
        input shell_bus_pkg::axil_data_t old_val,
        input shell_bus_pkg::axil_data_t new_val,
        input shell_bus_pkg::axil_strb_t strb
    );
        shell_bus_pkg::axil_data_t res;
        res = old_val;
        for (int i = 0; i < `SHELL_AXIL_DATA_W / 8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // --------------------
    // Handshakes
    // --------------------
    // Address and data must arrive together, one response in flight
    assign wr_acc = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
    assign rd_acc = axil_req.arvalid & ~rvalid_q;

    assign axil_rsp.awready = wr_acc;
    assign axil_rsp.wready  = wr_acc;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.arready = rd_acc;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;
    assign axil_rsp.rvalid  = rvalid_q;

    // Write decode, STATUS and ID accept writes but ignore them
    always_comb begin
        wr_known    = 1'b1;
        wr_ctrl     = 1'b0;
        wr_src      = 1'b0;
        wr_dst      = 1'b0;
        wr_len      = 1'b0;
        wr_irq_en   = 1'b0;
        wr_irq_stat = 1'b0;
        case (axil_req.awaddr)
            `SHELL_REG_CTRL:     wr_ctrl     = wr_acc;
            `SHELL_REG_SRC:      wr_src      = wr_acc;
            `SHELL_REG_DST:      wr_dst      = wr_acc;
            `SHELL_REG_LEN:      wr_len      = wr_acc;
            `SHELL_REG_IRQ_EN:   wr_irq_en   = wr_acc;
            `SHELL_REG_IRQ_STAT: wr_irq_stat = wr_acc;
            `SHELL_REG_STATUS, `SHELL_REG_ID: wr_known = 1'b1;
            default:             wr_known    = 1'b0;
        endcase
    end

    always_comb begin
        rd_word  = '0;
        rd_known = 1'b1;
        case (axil_req.araddr)
            `SHELL_REG_CTRL:     rd_word    = '0;
            `SHELL_REG_SRC:      rd_word    = src_q;
            `SHELL_REG_DST:      rd_word    = dst_q;
            `SHELL_REG_LEN:      rd_word    = len_q;
            `SHELL_REG_STATUS:   rd_word[0] = dma_busy;
            `SHELL_REG_IRQ_EN:   rd_word[0] = irq_en_q;
            `SHELL_REG_IRQ_STAT: rd_word[0] = irq_stat_q;
            `SHELL_REG_ID:       rd_word    = `SHELL_ID_VALUE;
            default:             rd_known   = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_acc) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_acc) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Response payload, held while valid waits for ready
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            bresp_q <= wr_known ? `SHELL_RESP_OKAY : `SHELL_RESP_SLVERR;
        end
        if (rd_acc) begin
            rdata_q <= rd_word;
            rresp_q <= rd_known ? `SHELL_RESP_OKAY : `SHELL_RESP_SLVERR;
        end
    end

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q      <= '0;
            dst_q      <= '0;
            len_q      <= '0;
            irq_en_q   <= 1'b0;
            irq_stat_q <= 1'b0;
            dma_start  <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            dma_start <= wr_ctrl & axil_req.wstrb[0] & axil_req.wdata[0];
            if (wr_src) begin
                src_q <= merge_bytes(src_q, axil_req.wdata, axil_req.wstrb);
            end
            if (wr_dst) begin
                dst_q <= merge_bytes(dst_q, axil_req.wdata, axil_req.wstrb);
            end
            if (wr_len) begin
                len_q <= merge_bytes(len_q, axil_req.wdata, axil_req.wstrb);
            end
            if (wr_irq_en && axil_req.wstrb[0]) begin
                irq_en_q <= axil_req.wdata[0];
            end
            // A done in the same cycle as the clear wins
            if (dma_done) begin
                irq_stat_q <= 1'b1;
            end else if (wr_irq_stat && axil_req.wstrb[0] && axil_req.wdata[0]) begin
                irq_stat_q <= 1'b0;
            end
            irq_q <= irq;
        end
    end

    assign dma_src = src_q[`SHELL_MEM_ADDR_W-1:0];
    assign dma_dst = dst_q[`SHELL_MEM_ADDR_W-1:0];
    assign dma_len = len_q[`SHELL_CNT_W-1:0];

    assign irq = irq_stat_q & irq_en_q;
    // Rising edge of irq
    assign msi = irq & ~irq_q;

endmodule

`default_nettype wire

/* source/shell_bus_pkg.sv */
// ------------------
// AXI-Lite request and response bundles
// and the single-word memory request
// ------------------
`default_nettype none

`include "shell_config.svh"

package shell_bus_pkg;

    typedef logic [`SHELL_AXIL_ADDR_W-1:0]   axil_addr_t;
    typedef logic [`SHELL_AXIL_DATA_W-1:0]   axil_data_t;
    typedef logic [`SHELL_AXIL_DATA_W/8-1:0] axil_strb_t;
    typedef logic [1:0]                      axil_resp_t;

    // Host to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // Slave to host
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic                      en;
        logic                      we;
        shell_dma_pkg::word_addr_t addr;
        shell_dma_pkg::mem_word_t  wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* source/shell_dma_pkg.sv */
// ------------------
// Word, address and count types and the
// copy engine state encoding
// ------------------
`default_nettype none

`include "shell_config.svh"

package shell_dma_pkg;

    // One memory word and its address
    typedef logic [`SHELL_DATA_W-1:0]     mem_word_t;
    typedef logic [`SHELL_MEM_ADDR_W-1:0] word_addr_t;

    // Copy length in words
    typedef logic [`SHELL_CNT_W-1:0]      word_count_t;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WAIT,
        WRITE,
        FINISH
    } dma_state_t;

endpackage

`default_nettype wire

/* source/shell_config.svh */
// ------------------
// Widths, memory depth, register map, ID value
// and AXI-Lite response codes for the memory shell
// ------------------
`ifndef SHELL_CONFIG_SVH
`define SHELL_CONFIG_SVH

// Datapath widths
`define SHELL_DATA_W       64
`define SHELL_MEM_ADDR_W   10
`define SHELL_MEM_DEPTH    (1 << `SHELL_MEM_ADDR_W)
`define SHELL_AXIL_ADDR_W  16
`define SHELL_AXIL_DATA_W  32
`define SHELL_CNT_W        16

// Register byte offsets
`define SHELL_REG_CTRL     16'h0000
`define SHELL_REG_SRC      16'h0004
`define SHELL_REG_DST      16'h0008
`define SHELL_REG_LEN      16'h000C
`define SHELL_REG_STATUS   16'h0010
`define SHELL_REG_IRQ_EN   16'h0014
`define SHELL_REG_IRQ_STAT 16'h0018
`define SHELL_REG_ID       16'h001C

`define SHELL_ID_VALUE     32'h564F_5831

`define SHELL_RESP_OKAY    2'b00
`define SHELL_RESP_SLVERR  2'b10

`endif
